// File: arbiter/column_arbiter.sv
`timescale 1ns/10ps

// Masked round-robin column grants inside the selected row
// One column per cycle, in ascending order, then the row is handed back
module column_arbiter #(
    parameter int ROWS = arbiter_pkg::ROWS,    // Rows in the grid
    parameter int COLS = arbiter_pkg::COLS     // Columns in the grid
) (
    input  logic                  clk_i,        // Clock
    input  logic                  reset_i,      // Asynchronous reset, active high
    input  logic                  enable_i,     // Global arbitration enable
    input  arbiter_pkg::row_sel_t row_sel_i,    // Row to be served
    input  logic [ROWS*COLS-1:0]  pending_i,    // Pending matrix, row-major
    output logic [COLS-1:0]       gnt_o,        // Registered one-hot column grant
    output logic                  row_done_o    // Nothing left under the mask
);

    logic [COLS-1:0] row_req;                   // Pending bits of the selected row
    logic [COLS-1:0] mask_ff;                   // Columns not yet served this visit
    logic [COLS-1:0] nxt_mask;                  // Mask past the column being granted
    logic [COLS-1:0] mask_req;                  // Row requests still under the mask
    logic [COLS-1:0] mask_gnt;                  // Lowest masked request
    logic [COLS-1:0] gnt_ff;                    // Grant register
    logic            active;                    // Arbitration allowed this cycle

    assign row_req  = pending_i[row_sel_i.row*COLS +: COLS];
    assign mask_req = row_req & mask_ff;
    assign active   = enable_i && row_sel_i.valid;

    priority_arb #(
        .WIDTH (COLS)
    ) u_col_arb (
        .req_i (mask_req),
        .gnt_o (mask_gnt)
    );

    // Everything at or below the granted column drops out of the mask
    always_comb
    begin
        nxt_mask = mask_ff;
        for (int i = 0; i < COLS; i++)
        begin
            if (mask_gnt[i])
            begin
                nxt_mask = {COLS{1'b1}} << (i + 1);
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            mask_ff <= {COLS{1'b1}};            // All columns open
            gnt_ff  <= '0;
        end
        else if (active && (|mask_req))
        begin
            mask_ff <= nxt_mask;
            gnt_ff  <= mask_gnt;                // Grant shows up one cycle later
        end
        else
        begin
            // Row finished, paused or idle, open the mask for the next visit
            mask_ff <= {COLS{1'b1}};
            gnt_ff  <= '0;
        end
    end

    assign gnt_o = gnt_ff;

    // Requests that came back behind the mask wait for the next visit
    assign row_done_o = active && !(|mask_req);

endmodule

// File: arbiter/request_matrix.sv
`timescale 1ns/10ps

// Input side of the arbiter
// Every cell latches its request pulse and keeps it until the cell is granted
module request_matrix #(
    parameter int ROWS = arbiter_pkg::ROWS,    // Rows in the grid
    parameter int COLS = arbiter_pkg::COLS     // Columns in the grid
) (
    input  logic                 clk_i,         // Clock
    input  logic                 reset_i,       // Asynchronous reset, active high
    input  logic [ROWS*COLS-1:0] req_i,         // Request pulses, row-major
    input  arbiter_pkg::row_sel_t row_sel_i,    // Row being served
    input  logic [COLS-1:0]      col_gnt_i,     // One-hot column grant of that row
    output logic [ROWS*COLS-1:0] pending_o,     // Sticky pending bits, row-major
    output logic [ROWS-1:0]      row_active_o   // Row has at least one pending cell
);

    logic [ROWS*COLS-1:0] pending_ff;           // Pending matrix
    logic [ROWS*COLS-1:0] clear;                // Cells granted this cycle

    // Build the clear pattern for the granted cell only
    always_comb
    begin
        clear = '0;
        for (int r = 0; r < ROWS; r++)
        begin
            if (row_sel_i.valid && (row_sel_i.row == r))
            begin
                clear[r*COLS +: COLS] = col_gnt_i;  // Grant lands in the selected row
            end
        end
    end

    // Set beats clear, so a fresh request on a granted cell stays pending
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            pending_ff <= '0;                   // Nothing outstanding after reset
        end
        else
        begin
            pending_ff <= (pending_ff & ~clear) | req_i;
        end
    end

    assign pending_o = pending_ff;

    // One OR per row tells the row arbiter where work is waiting
    always_comb
    begin
        for (int r = 0; r < ROWS; r++)
        begin
            row_active_o[r] = |pending_ff[r*COLS +: COLS];
        end
    end

endmodule

// File: arbiter/row_arbiter.sv
`timescale 1ns/10ps

// Round-robin row selection
// A chosen row is held until the column arbiter reports it finished
module row_arbiter #(
    parameter int ROWS = arbiter_pkg::ROWS     // Rows in the grid
) (
    input  logic                  clk_i,        // Clock
    input  logic                  reset_i,      // Asynchronous reset, active high
    input  logic                  enable_i,     // Global arbitration enable
    input  logic [ROWS-1:0]       row_active_i, // Rows with pending work
    input  logic                  row_done_i,   // Selected row has nothing left
    output arbiter_pkg::row_sel_t row_sel_o     // Registered row selection
);

    localparam int ROW_W = arbiter_pkg::ROW_ADD;

    logic [ROWS-1:0]       mask_ff;             // Rows still eligible in this round
    logic [ROWS-1:0]       nxt_mask;            // Mask past the row being picked
    logic [ROWS-1:0]       masked_req;          // Active rows above the last served
    logic [ROWS-1:0]       masked_gnt;          // Pick among masked rows
    logic [ROWS-1:0]       plain_gnt;           // Pick among all rows, wrap case
    logic [ROWS-1:0]       pick;                // Final one-hot row pick
    logic [ROW_W-1:0]      pick_idx;            // Binary index of the pick
    arbiter_pkg::row_sel_t sel_ff;              // Current selection

    assign masked_req = row_active_i & mask_ff;

    priority_arb #(
        .WIDTH (ROWS)
    ) u_masked_arb (
        .req_i (masked_req),
        .gnt_o (masked_gnt)
    );

    priority_arb #(
        .WIDTH (ROWS)
    ) u_plain_arb (
        .req_i (row_active_i),
        .gnt_o (plain_gnt)
    );

    // Fall back to the unmasked pick once the round is exhausted
    assign pick = (|masked_req) ? masked_gnt : plain_gnt;

    // Encode the pick and move the mask just past it
    always_comb
    begin
        pick_idx = '0;
        nxt_mask = mask_ff;
        for (int i = 0; i < ROWS; i++)
        begin
            if (pick[i])
            begin
                pick_idx = ROW_W'(i);
                nxt_mask = {ROWS{1'b1}} << (i + 1);  // Last row empties the mask
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            sel_ff  <= '0;
            mask_ff <= {ROWS{1'b1}};
        end
        else if (!enable_i)
        begin
            sel_ff.valid <= 1'b0;               // Pause, restart the round from row 0
            mask_ff      <= {ROWS{1'b1}};
        end
        else if (sel_ff.valid)
        begin
            if (row_done_i)
            begin
                sel_ff.valid <= 1'b0;           // One idle cycle between rows
            end
        end
        else if (|row_active_i)
        begin
            sel_ff.valid <= 1'b1;
            sel_ff.row   <= pick_idx;
            mask_ff      <= nxt_mask;
        end
    end

    assign row_sel_o = sel_ff;

endmodule

// File: common/arbiter_pkg.sv
// Shared sizes and records for the two-level matrix arbiter

package arbiter_pkg;

    // Default grid size, the top level overrides through its own parameters
    parameter int ROWS = 4;                     // Number of requester rows
    parameter int COLS = 8;                     // Number of requester columns

    // Address widths, kept at least one bit wide for degenerate grids
    parameter int ROW_ADD = (ROWS > 1) ? $clog2(ROWS) : 1;  // Row index width
    parameter int COL_ADD = (COLS > 1) ? $clog2(COLS) : 1;  // Column index width

    // Row chosen by the row arbiter for the column arbiter to work on
    typedef struct packed {
        logic               valid;              // A row is currently selected
        logic [ROW_ADD-1:0] row;                // Index of the selected row
    } row_sel_t;

    // One registered grant as seen at the output of the arbiter
    typedef struct packed {
        logic               valid;              // Strobe, high for one cycle per grant
        logic [ROW_ADD-1:0] row;                // Row address of the granted cell
        logic [COL_ADD-1:0] col;                // Column address of the granted cell
    } grant_t;

endpackage

// File: rtl/grant_encoder.sv
`timescale 1ns/10ps

// Output side, turns the one-hot column grant into an addressed grant record
module grant_encoder #(
    parameter int COLS = arbiter_pkg::COLS     // Columns in the grid
) (
    input  logic                  clk_i,        // Clock
    input  logic                  reset_i,      // Asynchronous reset, active high
    input  arbiter_pkg::row_sel_t row_sel_i,    // Row that owns the grant
    input  logic [COLS-1:0]       col_gnt_i,    // One-hot column grant
    output arbiter_pkg::grant_t   grant_o       // Registered grant record
);

    localparam int COL_W = arbiter_pkg::COL_ADD;
    localparam int ROW_W = arbiter_pkg::ROW_ADD;

    logic [COL_W-1:0] col_idx;                  // Binary column of the grant
    logic             valid_ff;                 // Grant strobe
    logic [ROW_W-1:0] row_ff;                   // Registered row address
    logic [COL_W-1:0] col_ff;                   // Registered column address

    // One-hot to binary, at most one bit is set
    always_comb
    begin
        col_idx = '0;
        for (int i = 0; i < COLS; i++)
        begin
            if (col_gnt_i[i])
            begin
                col_idx = COL_W'(i);
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            valid_ff <= 1'b0;
        end
        else
        begin
            valid_ff <= row_sel_i.valid && (|col_gnt_i);  // Strobe only on a real grant
        end
    end

    // Address fields are only meaningful while the strobe is high
    always_ff @(posedge clk_i)
    begin
        row_ff <= row_sel_i.row;
        col_ff <= col_idx;
    end

    assign grant_o = '{valid: valid_ff, row: row_ff, col: col_ff};

endmodule

// File: rtl/matrix_arbiter_top.sv
`timescale 1ns/10ps

// Two-level matrix arbiter for a ROWS x COLS grid of requesters
module matrix_arbiter_top #(
    parameter int ROWS = arbiter_pkg::ROWS,    // Rows in the grid
    parameter int COLS = arbiter_pkg::COLS     // Columns in the grid
) (
    input  logic                 clk_i,         // Clock
    input  logic                 reset_i,       // Asynchronous reset, active high
    input  logic                 enable_i,      // Pauses arbitration when low
    input  logic [ROWS*COLS-1:0] req_i,         // Request pulses, row-major
    output arbiter_pkg::grant_t  grant_o        // Registered grant with address
);

    logic [ROWS*COLS-1:0]  pending;             // Outstanding cells
    logic [ROWS-1:0]       row_active;          // Rows with work
    arbiter_pkg::row_sel_t row_sel;             // Row under service
    logic [COLS-1:0]       col_gnt;             // One-hot column grant
    logic                  row_done;            // Row finished, pick another

    request_matrix #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_request_matrix (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req_i        (req_i),
        .row_sel_i    (row_sel),
        .col_gnt_i    (col_gnt),
        .pending_o    (pending),
        .row_active_o (row_active)
    );

    row_arbiter #(
        .ROWS (ROWS)
    ) u_row_arbiter (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .enable_i     (enable_i),
        .row_active_i (row_active),
        .row_done_i   (row_done),
        .row_sel_o    (row_sel)
    );

    column_arbiter #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_column_arbiter (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .enable_i   (enable_i),
        .row_sel_i  (row_sel),
        .pending_i  (pending),
        .gnt_o      (col_gnt),
        .row_done_o (row_done)
    );

    grant_encoder #(
        .COLS (COLS)
    ) u_grant_encoder (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .row_sel_i (row_sel),
        .col_gnt_i (col_gnt),
        .grant_o   (grant_o)
    );

endmodule

// File: rtl/priority_arb.sv
`timescale 1ns/10ps

// Fixed priority arbiter, bit 0 has the highest priority
module priority_arb #(
    parameter int WIDTH = 8                     // Number of request lines
) (
    input  logic [WIDTH-1:0] req_i,             // Request vector
    output logic [WIDTH-1:0] gnt_o              // One-hot grant, zero when idle
);

    logic found;                                // A lower index already won

    always_comb
    begin
        gnt_o = '0;
        found = 1'b0;
        // Walk upward and keep only the first set request
        for (int i = 0; i < WIDTH; i++)
        begin
            if (req_i[i] && !found)
            begin
                gnt_o[i] = 1'b1;
                found    = 1'b1;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the matrix arbiter testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module matrix_arbiter_tb -o matrix_arbiter_sim

out=$(./obj_dir/matrix_arbiter_sim)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// File: sim.f
common/arbiter_pkg.sv
rtl/priority_arb.sv
arbiter/request_matrix.sv
arbiter/row_arbiter.sv
arbiter/column_arbiter.sv
rtl/grant_encoder.sv
rtl/matrix_arbiter_top.sv
test/tb_clock_gen.sv
test/matrix_arbiter_tb.sv

// File: test/matrix_arbiter_tb.sv
`timescale 1ns/10ps

// Testbench for the two-level matrix arbiter
// A shadow matrix of outstanding requests follows every pulse and every grant
module matrix_arbiter_tb;

    localparam int ROWS      = arbiter_pkg::ROWS;
    localparam int COLS      = arbiter_pkg::COLS;
    localparam int CELLS     = ROWS * COLS;
    localparam int CELL_W    = $clog2(CELLS);
    localparam int RAND_LEN  = 400;             // Random traffic cycles
    localparam int EN_PRE    = 60;              // Traffic before the pause
    localparam int EN_LOW    = 40;              // Cycles with enable low
    localparam int DRAIN_MAX = 150;             // Bound for emptying the grid
    localparam int SETTLE    = 8;               // Quiet cycles after a drain
    localparam int TEST_CYCLES = 16 + (RAND_LEN + 1 + DRAIN_MAX + SETTLE)
                               + (EN_PRE + EN_LOW + 2 + DRAIN_MAX + SETTLE)
                               + (2 + DRAIN_MAX + SETTLE);
    localparam int TIMEOUT   = TEST_CYCLES + 200;

    logic                      clk;
    logic                      reset;
    logic                      enable;
    logic [CELLS-1:0]          req;
    arbiter_pkg::grant_t       grant;

    logic [CELLS-1:0]          open_cells = '0; // Requests not yet granted
    logic [ROWS-1:0][ROWS-1:0] owed = '0;       // Row r may not return before row s
    logic                      prev_valid = 1'b0;
    int                        visit_row = 0;   // Row of the current visit
    int                        last_col = 0;    // Last column granted in it
    int                        low_cnt = 0;     // Edges seen with enable low
    logic                      full_mode = 1'b0;
    int                        full_cnt = 0;
    int                        full_row0 = 0;   // First row served in the full grid
    logic [15:0]               lfsr = 16'd56041;
    string                     cur_test = "reset";
    int                        test_errs = 0;
    int                        total_errs = 0;
    int                        tests_run = 0;
    int                        tests_bad = 0;
    int                        cycle_cnt = 0;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    matrix_arbiter_top #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_matrix_arbiter_top (
        .clk_i    (clk),
        .reset_i  (reset),
        .enable_i (enable),
        .req_i    (req),
        .grant_o  (grant)
    );

    // Taps 16, 14, 13, 11
    function automatic logic step_lfsr();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
            v = (v << 1) | int'(step_lfsr());  // One step per bit
        return v;
    endfunction

    function automatic int lowest_open(input int r);
        int c;
        c = -1;
        for (int i = COLS - 1; i >= 0; i--)
            if (open_cells[r*COLS + i])
                c = i;
        return c;
    endfunction

    task automatic value_error(input string what, input int exp, input int act);
        $display("ERROR %s: %s, expected %0d, actual %0d", cur_test, what, exp, act);
        test_errs++;
        total_errs++;
    endtask

    task automatic cell_error(input string what, input int er, input int ec,
                              input int ar, input int ac);
        $display("ERROR %s: %s, expected row %0d col %0d, actual row %0d col %0d",
                 cur_test, what, er, ec, ar, ac);
        test_errs++;
        total_errs++;
    endtask

    task automatic plain_error(input string msg);
        $display("ERROR %s: %s", cur_test, msg);
        test_errs++;
        total_errs++;
    endtask

    // Reference model and checks on the rising edge
    always @(posedge clk)
    begin
        int ar;
        int ac;
        int k;
        int er;
        int ec;
        int w;
        ar = int'(grant.row);
        ac = int'(grant.col);
        if (reset)
        begin
            a_reset: assert (!grant.valid) else value_error("valid in reset", 0, 1);
        end
        else
        begin
            if (low_cnt >= 2)                   // In-flight grant may still leave
                a_pause: assert (!grant.valid) else value_error("valid while paused", 0, 1);
            if (grant.valid)
            begin
                k = ar*COLS + ac;
                a_once: assert (open_cells[k])
                    else cell_error("cell not outstanding", ar, lowest_open(ar), ar, ac);
                open_cells[k] = 1'b0;
                if (prev_valid && ar == visit_row)
                begin
                    a_asc: assert (ac > last_col)
                        else cell_error("column not ascending", ar, last_col + 1, ar, ac);
                end
                else if (enable)                // A new visit may not jump a waiting row
                begin
                    w = -1;
                    for (int s = 0; s < ROWS; s++)
                        if (owed[ar][s])
                            w = s;
                    a_rr: assert (w < 0)
                        else plain_error($sformatf("row %0d served again while row %0d waits",
                                                   ar, w));
                    for (int s = 0; s < ROWS; s++)
                    begin
                        owed[s][ar] = 1'b0;
                        owed[ar][s] = (s != ar) && (|open_cells[s*COLS +: COLS]);
                    end
                end
                visit_row = ar;
                last_col  = ac;
                if (full_mode)
                begin
                    if (full_cnt == 0)
                        full_row0 = ar;
                    er = (full_row0 + full_cnt / COLS) % ROWS;  // Rows in turn
                    ec = full_cnt % COLS;                       // Runs of 0..COLS-1
                    a_full: assert (ar == er && ac == ec)
                        else cell_error("full grid order", er, ec, ar, ac);
                    full_cnt++;
                end
            end
            open_cells = open_cells | req;      // Pulse is pending after this edge
            if (!enable)
            begin
                low_cnt++;
                owed = '0;                      // Pause restarts the round at row 0
            end
            else
                low_cnt = 0;
        end
        prev_valid = grant.valid;
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT)
        begin
            $display("timeout, run stopped after %0d cycles", cycle_cnt);
            $display("test failed");
            $finish;
        end
    end

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errs != 0)
            tests_bad++;
        $display("%s: %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "FAILED", test_errs);
    endtask

    // Up to two fresh cells per cycle and never one still outstanding
    task automatic drive_random(input int cycles);
        int idx;
        int fire;
        for (int c = 0; c < cycles; c++)
        begin
            @(negedge clk);
            req = '0;
            repeat (2)
            begin
                idx  = random_bits(CELL_W) % CELLS;
                fire = random_bits(1);
                if (fire == 1 && !open_cells[idx])
                    req[idx] = 1'b1;
            end
        end
        @(negedge clk);
        req = '0;
    endtask

    task automatic drain_wait();
        int n;
        n = 0;
        while (open_cells != '0 && n < DRAIN_MAX)
        begin
            @(negedge clk);
            n++;
        end
        repeat (SETTLE) @(negedge clk);        // Late duplicates would show here
        a_drain: assert (open_cells == '0)
            else value_error("cells left after drain", 0, $countones(open_cells));
    endtask

    initial
    begin
        req    = '0;
        enable = 1'b1;
        start_test("reset");
        @(negedge reset);                       // Release comes on a falling clock edge
        repeat (5) @(negedge clk);
        finish_test();

        start_test("random");
        drive_random(RAND_LEN);
        drain_wait();
        finish_test();

        start_test("enable");
        drive_random(EN_PRE);
        enable = 1'b0;
        drive_random(EN_LOW);                   // These wait for the restart
        enable = 1'b1;
        drain_wait();
        finish_test();

        start_test("full_grid");
        full_cnt  = 0;
        full_mode = 1'b1;
        @(negedge clk);
        req = '1;
        @(negedge clk);
        req = '0;
        drain_wait();
        a_count: assert (full_cnt == CELLS) else value_error("grant count", CELLS, full_cnt);
        full_mode = 1'b0;
        finish_test();

        $display("tests run %0d, ok %0d, failing %0d", tests_run, tests_run - tests_bad,
                 tests_bad);
        if (tests_bad == 0 && total_errs == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/10ps

// Free-running testbench clock and power-on reset
module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,             // Half of the 10 ns period
    parameter int RESET_CYCLES = 10             // Cycles with reset held high
) (
    output logic clk_o,                         // Testbench clock
    output logic reset_o                        // Active-high reset
);

    initial
    begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the DUT's sampling edge
    initial
    begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule
